/* list.f */
source/video_pkg.sv
source/sprite_pkg.sv
source/vga_sync_generator.sv
source/sprite_registers.sv
source/sprite_line_counter.sv
source/sprite_colour_memory.sv
source/sprite_engine_top.sv
test/sprite_engine_assertions.sv
test/sprite_engine_tb.sv

/* Makefile */
SOURCES := $(wildcard source/*.sv test/*.sv)

.PHONY: run clean

run: obj_dir/sprite_engine_sim
	@out=$$(./obj_dir/sprite_engine_sim +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

obj_dir/sprite_engine_sim: list.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module sprite_engine_tb \
		-f list.f -Mdir obj_dir -o sprite_engine_sim

clean:
	rm -rf obj_dir

/* test/sprite_engine_tb.sv */
module sprite_engine_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clock_period = 40; // ns per pixel.
	localparam int watchdog_ns = 5 * video_pkg::h_total * video_pkg::v_total * clock_period;

	logic clk_pixel;
	logic reset;
	sprite_pkg::apb_request_t apb;
	logic [31:0] prdata;
	logic pready;
	logic hsync;
	logic vsync;
	logic active;
	video_pkg::pixel_x_t pixel_x;
	video_pkg::pixel_y_t pixel_y;
	video_pkg::colour_t colour;

	logic [31:0] random_state = 32'hd137_08fb; // xorshift state.
	video_pkg::colour_t model_memory [sprite_pkg::colour_memory_depth]; // mirror of the dut.
	video_pkg::colour_t model_background = '0;
	sprite_pkg::sprite_descriptor_t model_descriptor = '0;
	video_pkg::colour_t expected_pixel;
	string test_name = "reset";
	int value_errors = 0;
	int pixel_errors = 0;
	int assertion_errors = 0;

	sprite_engine_top i_sprite_engine_top (
		.clk_pixel(clk_pixel),
		.reset(reset),
		.apb(apb),
		.prdata(prdata),
		.pready(pready),
		.hsync(hsync),
		.vsync(vsync),
		.active(active),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.colour(colour)
	);

	bind sprite_engine_top sprite_engine_assertions i_sprite_engine_assertions (
		.clk_pixel(clk_pixel),
		.reset(reset),
		.apb(apb),
		.pready(pready),
		.hsync(hsync),
		.vsync(vsync),
		.active(active),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.colour(colour),
		.count_finished(count_finished)
	);

	initial begin
		clk_pixel = 1'b0;
		forever #(clock_period / 2) clk_pixel = ~clk_pixel;
	end

	initial begin
		#(watchdog_ns);
		$display("timeout: frames did not complete within %0d ns", watchdog_ns);
		$display("Simulation FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] value);
		logic [31:0] next;
		next = value ^ (value << 13);
		next = next ^ (next >> 17);
		next = next ^ (next << 5);
		return next;
	endfunction

	// background, or the sprite entry at (offset + row * width + column) mod depth.
	function automatic video_pkg::colour_t expected_colour(input video_pkg::pixel_x_t x,
		input video_pkg::pixel_y_t y);
		int column;
		int row;
		int index;
		column = int'(x) - int'(model_descriptor.x);
		row = int'(y) - int'(model_descriptor.y);
		if (!model_descriptor.enable || column < 0 || column >= sprite_pkg::sprite_width ||
			row < 0 || row >= sprite_pkg::sprite_height) begin
			return model_background;
		end
		index = (int'(model_descriptor.offset) + row * sprite_pkg::sprite_width + column) %
			sprite_pkg::colour_memory_depth;
		return model_memory[index];
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			value_errors++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	////////////////////////////////////////////////////////////
	// apb access
	////////////////////////////////////////////////////////////

	task automatic apb_write(input sprite_pkg::register_address_t address,
		input logic [31:0] data);
		@(posedge clk_pixel);
		apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: address, pwdata: data};
		@(posedge clk_pixel);
		apb.penable <= 1'b1; // access phase, write lands on the next edge.
		@(posedge clk_pixel);
		apb <= '0;
	endtask

	task automatic apb_read_check(input string name, input sprite_pkg::register_address_t address,
		input logic [31:0] expected);
		logic [31:0] data;
		@(posedge clk_pixel);
		apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: address, pwdata: '0};
		@(posedge clk_pixel);
		apb.penable <= 1'b1;
		@(negedge clk_pixel);
		data = prdata; // mid access phase.
		@(posedge clk_pixel);
		apb <= '0;
		check_value(name, expected, data);
	endtask

	task automatic fill_memory();
		for (int i = 0; i < sprite_pkg::colour_memory_depth; i++) begin
			random_state = xorshift(random_state);
			model_memory[i] = random_state[7:0]; // only the low byte is stored.
			apb_write(sprite_pkg::address_memory_base + sprite_pkg::register_address_t'(i * 4),
				random_state);
		end
	endtask

	task automatic program_sprite(input logic sprite_enable, input logic [8:0] sprite_x,
		input logic [8:0] sprite_y, input sprite_pkg::colour_address_t sprite_offset);
		model_descriptor = '{enable: sprite_enable, spare: 4'd0, x: sprite_x, y: sprite_y,
			offset: sprite_offset};
		apb_write(sprite_pkg::address_descriptor, model_descriptor);
	endtask

	////////////////////////////////////////////////////////////
	// frame pacing
	////////////////////////////////////////////////////////////

	task automatic wait_vertical_blank();
		do @(negedge clk_pixel); while (pixel_y != video_pkg::pixel_y_t'(video_pkg::v_visible));
	endtask

	task automatic run_frame(input string name);
		test_name = name;
		do @(negedge clk_pixel); while (!(active && pixel_x == '0 && pixel_y == '0));
		wait_vertical_blank(); // whole visible area checked.
	endtask

	// every output pixel against the model, once out of reset.
	always @(negedge clk_pixel) begin
		if (reset) begin
			expected_pixel = active ? expected_colour(pixel_x, pixel_y) : '0;
			if (colour !== expected_pixel) begin
				pixel_errors++;
				if (pixel_errors <= 20) begin
					$display("FAILED %s at (%0d, %0d): expected %h, actual %h", test_name,
						pixel_x, pixel_y, expected_pixel, colour);
				end
			end
		end
	end

	initial begin
		reset = 1'b0;
		apb = '0;
		repeat (4) @(posedge clk_pixel);
		@(negedge clk_pixel);
		check_value("reset hsync", 32'd1, hsync);
		check_value("reset vsync", 32'd1, vsync);
		check_value("reset active", 32'd0, active);
		check_value("reset colour", 32'd0, colour);
		@(posedge clk_pixel);
		reset <= 1'b1; // released after the fifth edge.
		apb_read_check("reset descriptor", sprite_pkg::address_descriptor, 32'd0);
		apb_read_check("reset background", sprite_pkg::address_background, 32'd0);
		test_name = "reset_frame";
		wait_vertical_blank();
		random_state = xorshift(random_state);
		model_background = random_state[7:0];
		apb_write(sprite_pkg::address_background, random_state);
		fill_memory();
		apb_read_check("memory read", sprite_pkg::address_memory_base, 32'd0);
		run_frame("disabled_sprite");
		program_sprite(1'b1, 9'd100, 9'd50, 9'd37);
		apb_read_check("descriptor read", sprite_pkg::address_descriptor, model_descriptor);
		run_frame("sprite_image");
		program_sprite(1'b1, 9'd491, 9'd470, 9'd500); // bottom rows fall in blanking.
		run_frame("wrap_and_clip");
		assertion_errors = i_sprite_engine_top.i_sprite_engine_assertions.failure_count;
		$display("errors: value %0d, pixel %0d, assertion %0d", value_errors, pixel_errors,
			assertion_errors);
		if (value_errors == 0 && pixel_errors == 0 && assertion_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* test/sprite_engine_assertions.sv */
module sprite_engine_assertions (
	input logic clk_pixel,
	input logic reset,
	input sprite_pkg::apb_request_t apb,
	input logic pready,
	input logic hsync,
	input logic vsync,
	input logic active,
	input video_pkg::pixel_x_t pixel_x,
	input video_pkg::pixel_y_t pixel_y,
	input video_pkg::colour_t colour,
	input logic count_finished
);
	timeunit 1ns;
	timeprecision 1ps;

	int failure_count = 0; // failed assertions so far.
	int reset_cycles = 0; // clocks seen with reset held low.
	int h_low; // clocks of the current hsync pulse.
	int v_low; // clocks of the current vsync pulse.
	int h_period; // clocks since the last hsync fall.
	logic h_seen; // a full line has been observed.
	logic hsync_last; // hsync one clock back.

	always @(posedge clk_pixel) begin
		reset_cycles <= reset ? 0 : reset_cycles + 1;
	end

	////////////////////////////////////////////////////////////
	// pulse and period counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_pixel or negedge reset) begin
		if (!reset) begin
			h_low <= 0;
			v_low <= 0;
			h_period <= 0;
			h_seen <= 1'b0;
			hsync_last <= 1'b1;
		end else begin
			hsync_last <= hsync;
			h_low <= hsync ? 0 : h_low + 1; // counts only while low.
			v_low <= vsync ? 0 : v_low + 1;
			if (hsync_last && !hsync) begin
				h_period <= 1; // falling edge starts a new line.
				h_seen <= 1'b1;
			end else begin
				h_period <= h_period + 1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// properties
	////////////////////////////////////////////////////////////

	reset_outputs: assert property (@(posedge clk_pixel)
		(!reset && reset_cycles >= 1) |-> (hsync && vsync && !active && colour == '0 &&
		count_finished))
	else begin
		failure_count++;
		$error("outputs are not at their reset values while reset is held");
	end

	hsync_width: assert property (@(posedge clk_pixel) disable iff (!reset)
		$rose(hsync) |-> h_low == video_pkg::h_sync)
	else begin
		failure_count++;
		$error("hsync pulse width is %0d clocks", h_low);
	end

	hsync_period: assert property (@(posedge clk_pixel) disable iff (!reset)
		(h_seen && $fell(hsync)) |-> h_period == video_pkg::h_total)
	else begin
		failure_count++;
		$error("hsync period is %0d clocks", h_period);
	end

	hsync_start: assert property (@(posedge clk_pixel) disable iff (!reset)
		$fell(hsync) |-> pixel_x == video_pkg::pixel_x_t'(video_pkg::h_sync_start))
	else begin
		failure_count++;
		$error("hsync does not fall at the first sync column");
	end

	vsync_width: assert property (@(posedge clk_pixel) disable iff (!reset)
		$rose(vsync) |-> v_low == video_pkg::v_sync * video_pkg::h_total)
	else begin
		failure_count++;
		$error("vsync pulse is %0d clocks long", v_low);
	end

	vsync_start: assert property (@(posedge clk_pixel) disable iff (!reset)
		$fell(vsync) |-> (pixel_y == video_pkg::pixel_y_t'(video_pkg::v_sync_start) &&
		pixel_x == '0))
	else begin
		failure_count++;
		$error("vsync does not fall at the start of the first sync line");
	end

	blank_inactive: assert property (@(posedge clk_pixel) disable iff (!reset)
		(pixel_x >= video_pkg::pixel_x_t'(video_pkg::h_visible) ||
		pixel_y >= video_pkg::pixel_y_t'(video_pkg::v_visible)) |-> !active)
	else begin
		failure_count++;
		$error("active is high outside the visible area");
	end

	visible_active: assert property (@(posedge clk_pixel) disable iff (!reset)
		(h_seen && pixel_x < video_pkg::pixel_x_t'(video_pkg::h_visible) &&
		pixel_y < video_pkg::pixel_y_t'(video_pkg::v_visible)) |-> active)
	else begin
		failure_count++;
		$error("active is low inside the visible area");
	end

	apb_ready: assert property (@(posedge clk_pixel) disable iff (!reset)
		(apb.psel && apb.penable) |-> pready)
	else begin
		failure_count++;
		$error("pready is low in an access phase");
	end

endmodule

/* source/sprite_engine_top.sv */
module sprite_engine_top (
	input logic clk_pixel,
	input logic reset,
	input sprite_pkg::apb_request_t apb,
	output logic [31:0] prdata,
	output logic pready,
	output logic hsync,
	output logic vsync,
	output logic active,
	output video_pkg::pixel_x_t pixel_x,
	output video_pkg::pixel_y_t pixel_y,
	output video_pkg::colour_t colour
);

	sprite_pkg::sprite_descriptor_t descriptor;
	video_pkg::colour_t background;
	logic memory_write;
	sprite_pkg::colour_address_t memory_write_address;
	video_pkg::colour_t memory_write_data;
	video_pkg::video_timing_t timing; // from the sync generator.
	sprite_pkg::colour_address_t memory_address;
	logic sprite_hit;
	logic count_finished; // row status of the line counter.
	video_pkg::colour_t read_colour;
	video_pkg::video_timing_t timing_line; // aligned with memory_address.
	video_pkg::video_timing_t timing_memory; // aligned with read_colour.
	logic hit_memory; // sprite_hit aligned with read_colour.
	video_pkg::video_timing_t video_out; // registered with colour.

	sprite_registers i_sprite_registers (
		.clk_pixel(clk_pixel),
		.reset(reset),
		.apb(apb),
		.prdata(prdata),
		.pready(pready),
		.descriptor(descriptor),
		.background(background),
		.memory_write(memory_write),
		.memory_write_address(memory_write_address),
		.memory_write_data(memory_write_data)
	);

	vga_sync_generator i_vga_sync_generator (
		.clk_pixel(clk_pixel),
		.reset(reset),
		.timing(timing)
	);

	sprite_line_counter i_sprite_line_counter (
		.clk_pixel(clk_pixel),
		.reset(reset),
		.pixel_x(timing.x),
		.pixel_y(timing.y),
		.descriptor(descriptor),
		.memory_address(memory_address),
		.sprite_hit(sprite_hit),
		.count_finished(count_finished)
	);

	sprite_colour_memory i_sprite_colour_memory (
		.clk_pixel(clk_pixel),
		.memory_write(memory_write),
		.memory_write_address(memory_write_address),
		.memory_write_data(memory_write_data),
		.memory_address(memory_address),
		.read_colour(read_colour)
	);

	////////////////////////////////////////////////////////////
	// timing delay and colour select
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_pixel or negedge reset) begin
		if (!reset) begin
			timing_line <= video_pkg::timing_idle;
			timing_memory <= video_pkg::timing_idle;
			video_out <= video_pkg::timing_idle; // syncs high, inactive.
			hit_memory <= 1'b0;
			colour <= '0;
		end else begin
			timing_line <= timing; // line counter stage.
			timing_memory <= timing_line; // memory read stage.
			hit_memory <= sprite_hit;
			video_out <= timing_memory;
			if (!timing_memory.active) begin
				colour <= '0; // black in blanking.
			end else if (hit_memory) begin
				colour <= read_colour; // sprite pixel.
			end else begin
				colour <= background;
			end
		end
	end

	assign hsync = video_out.hsync;
	assign vsync = video_out.vsync;
	assign active = video_out.active;
	assign pixel_x = video_out.x; // coordinate of the pixel on colour.
	assign pixel_y = video_out.y;

endmodule

/* source/sprite_colour_memory.sv */
module sprite_colour_memory (
	input logic clk_pixel,
	input logic memory_write,
	input sprite_pkg::colour_address_t memory_write_address,
	input video_pkg::colour_t memory_write_data,
	input sprite_pkg::colour_address_t memory_address,
	output video_pkg::colour_t read_colour
);

	video_pkg::colour_t storage [sprite_pkg::colour_memory_depth]; // sprite pixels.

	// write port from the apb slave.
	always_ff @(posedge clk_pixel) begin
		if (memory_write) begin
			storage[memory_write_address] <= memory_write_data;
		end
	end

	// pixel read port, one cycle latency.
	always_ff @(posedge clk_pixel) begin
		read_colour <= storage[memory_address];
	end

endmodule

/* source/sprite_line_counter.sv */
module sprite_line_counter (
	input logic clk_pixel,
	input logic reset,
	input video_pkg::pixel_x_t pixel_x,
	input video_pkg::pixel_y_t pixel_y,
	input sprite_pkg::sprite_descriptor_t descriptor,
	output sprite_pkg::colour_address_t memory_address,
	output logic sprite_hit,
	output logic count_finished
);

	typedef enum logic {
		idle,
		counting
	} line_state_t;

	line_state_t state;
	logic [4:0] column; // column of the current pixel while counting.
	logic [4:0] column_now; // zero on the starting pixel.
	sprite_pkg::colour_address_t row_base; // first entry of the next row.
	sprite_pkg::colour_address_t line_base; // first entry of this row.
	video_pkg::pixel_x_t sprite_left;
	video_pkg::pixel_y_t sprite_top;
	logic row_in_span; // pixel_y inside the sprite rows.
	logic first_row;
	logic start; // first column of a sprite row.
	logic in_sprite; // current pixel belongs to the sprite.
	logic last_column;

	assign sprite_left = video_pkg::pixel_x_t'(descriptor.x); // zero extended.
	assign sprite_top = video_pkg::pixel_y_t'(descriptor.y);
	assign row_in_span = (pixel_y >= sprite_top) &&
		(pixel_y < sprite_top + video_pkg::pixel_y_t'(sprite_pkg::sprite_height));
	assign first_row = pixel_y == sprite_top;
	assign start = (state == idle) && row_in_span && (pixel_x == sprite_left);
	assign in_sprite = start || (state == counting);
	assign column_now = (state == counting) ? column : 5'd0;
	assign last_column = in_sprite && (column_now == 5'(sprite_pkg::sprite_width - 1));
	assign line_base = first_row ? descriptor.offset : row_base; // offset on the top row.

	////////////////////////////////////////////////////////////
	// column fsm
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_pixel or negedge reset) begin
		if (!reset) begin
			state <= idle;
			column <= '0;
			row_base <= '0;
			sprite_hit <= 1'b0;
			count_finished <= 1'b1; // no row in progress.
		end else begin
			sprite_hit <= in_sprite && descriptor.enable;
			count_finished <= !in_sprite || last_column; // high outside a row and on its end.
			if (last_column) begin
				state <= idle;
				column <= '0;
				row_base <= line_base + sprite_pkg::colour_address_t'(sprite_pkg::sprite_width);
			end else if (in_sprite) begin
				state <= counting;
				column <= column_now + 1'b1;
			end
		end
	end

	// offset plus row base plus column, wraps at 512.
	always_ff @(posedge clk_pixel) begin
		memory_address <= line_base + sprite_pkg::colour_address_t'(column_now);
	end

endmodule

/* source/sprite_registers.sv */
module sprite_registers (
	input logic clk_pixel,
	input logic reset,
	input sprite_pkg::apb_request_t apb,
	output logic [31:0] prdata,
	output logic pready,
	output sprite_pkg::sprite_descriptor_t descriptor,
	output video_pkg::colour_t background,
	output logic memory_write,
	output sprite_pkg::colour_address_t memory_write_address,
	output video_pkg::colour_t memory_write_data
);

	logic register_write; // access phase of a write.
	logic memory_window; // address falls in the colour memory.
	sprite_pkg::register_address_t memory_offset; // byte offset into the window.

	assign register_write = apb.psel && apb.penable && apb.pwrite;
	assign memory_window = apb.paddr >= sprite_pkg::address_memory_base;
	assign memory_offset = apb.paddr - sprite_pkg::address_memory_base;
	assign pready = 1'b1; // no wait states.

	////////////////////////////////////////////////////////////
	// control registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_pixel or negedge reset) begin
		if (!reset) begin
			descriptor <= '0; // sprite disabled.
			background <= '0;
			memory_write <= 1'b0;
		end else begin
			memory_write <= register_write && memory_window; // one cycle pulse.
			if (register_write && !memory_window) begin
				case (apb.paddr)
					sprite_pkg::address_descriptor: begin
						descriptor <= sprite_pkg::sprite_descriptor_t'(apb.pwdata);
					end
					sprite_pkg::address_background: begin
						background <= apb.pwdata[7:0]; // low byte only.
					end
					default: begin
						// unmapped register addresses are ignored.
					end
				endcase
			end
		end
	end

	// memory write payload that goes with the pulse above.
	always_ff @(posedge clk_pixel) begin
		if (register_write && memory_window) begin
			memory_write_address <= memory_offset[10:2]; // word index 0 to 511.
			memory_write_data <= apb.pwdata[7:0];
		end
	end

	////////////////////////////////////////////////////////////
	// read data
	////////////////////////////////////////////////////////////

	always_comb begin
		case (apb.paddr)
			sprite_pkg::address_descriptor: prdata = descriptor;
			sprite_pkg::address_background: prdata = {24'd0, background};
			default: prdata = 32'd0; // memory space reads as zero.
		endcase
	end

endmodule

/* source/vga_sync_generator.sv */
module vga_sync_generator (
	input logic clk_pixel,
	input logic reset,
	output video_pkg::video_timing_t timing
);

	video_pkg::pixel_x_t h_count; // column being generated.
	video_pkg::pixel_y_t v_count; // line being generated.
	logic h_last; // last clock of a line.
	logic v_last; // last line of a frame.

	assign h_last = h_count == video_pkg::pixel_x_t'(video_pkg::h_total - 1);
	assign v_last = v_count == video_pkg::pixel_y_t'(video_pkg::v_total - 1);

	////////////////////////////////////////////////////////////
	// counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_pixel or negedge reset) begin
		if (!reset) begin
			h_count <= '0;
			v_count <= '0;
		end else begin
			if (h_last) begin
				h_count <= '0; // wrap at h_total.
				if (v_last) begin
					v_count <= '0; // new frame.
				end else begin
					v_count <= v_count + 1'b1; // next line.
				end
			end else begin
				h_count <= h_count + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// registered timing flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_pixel or negedge reset) begin
		if (!reset) begin
			timing <= video_pkg::timing_idle; // syncs high, not active.
		end else begin
			timing.x <= h_count;
			timing.y <= v_count;
			timing.active <= (h_count < video_pkg::h_visible) &&
				(v_count < video_pkg::v_visible); // visible window.
			timing.hsync <= !((h_count >= video_pkg::h_sync_start) &&
				(h_count < video_pkg::h_sync_end)); // low for h_sync clocks.
			timing.vsync <= !((v_count >= video_pkg::v_sync_start) &&
				(v_count < video_pkg::v_sync_end)); // low for v_sync lines.
		end
	end

endmodule

/* source/sprite_pkg.sv */
package sprite_pkg;

	////////////////////////////////////////////////////////////
	// sprite geometry and colour memory
	////////////////////////////////////////////////////////////

	localparam int sprite_width = 20; // pixels per sprite row.
	localparam int sprite_height = 20; // rows per sprite.
	localparam int colour_memory_depth = 512; // entries in the colour memory.

	typedef logic [8:0] colour_address_t; // wraps modulo colour_memory_depth.

	// sprite descriptor word.
	typedef struct packed {
		logic enable; // bit 31.
		logic [3:0] spare; // bits 30:27 are unused.
		logic [8:0] x; // left column in bits 26:18.
		logic [8:0] y; // top row in bits 17:9.
		colour_address_t offset; // first memory entry in bits 8:0.
	} sprite_descriptor_t;

	////////////////////////////////////////////////////////////
	// apb register map
	////////////////////////////////////////////////////////////

	typedef logic [11:0] register_address_t; // byte address on the bus.

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		register_address_t paddr;
		logic [31:0] pwdata;
	} apb_request_t;

	localparam register_address_t address_descriptor = 12'h000; // sprite descriptor word.
	localparam register_address_t address_background = 12'h004; // background colour.
	localparam register_address_t address_memory_base = 12'h800; // colour memory window.

endpackage

/* source/video_pkg.sv */
package video_pkg;

	////////////////////////////////////////////////////////////
	// 640 x 480 display timing
	////////////////////////////////////////////////////////////

	localparam int h_visible = 640; // visible pixels per line.
	localparam int h_front = 16; // pixels before the sync pulse.
	localparam int h_sync = 96; // sync pulse width in pixels.
	localparam int h_back = 48; // pixels after the sync pulse.
	localparam int h_total = h_visible + h_front + h_sync + h_back; // 800 clocks per line.

	localparam int v_visible = 480; // visible lines per frame.
	localparam int v_front = 10; // lines before the sync pulse.
	localparam int v_sync = 2; // sync pulse width in lines.
	localparam int v_back = 33; // lines after the sync pulse.
	localparam int v_total = v_visible + v_front + v_sync + v_back; // 525 lines per frame.

	localparam int h_sync_start = h_visible + h_front; // first low clock of hsync.
	localparam int h_sync_end = h_sync_start + h_sync; // first high clock after the pulse.
	localparam int v_sync_start = v_visible + v_front; // first low line of vsync.
	localparam int v_sync_end = v_sync_start + v_sync; // first high line after the pulse.

	////////////////////////////////////////////////////////////
	// pixel types
	////////////////////////////////////////////////////////////

	typedef logic [9:0] pixel_x_t; // column from 0 to h_total - 1.
	typedef logic [9:0] pixel_y_t; // row from 0 to v_total - 1.
	typedef logic [7:0] colour_t; // rgb332.

	typedef struct packed {
		pixel_x_t x; // current column.
		pixel_y_t y; // current row.
		logic hsync; // active low.
		logic vsync; // active low.
		logic active; // inside the visible area.
	} video_timing_t;

	// timing value held during reset.
	localparam video_timing_t timing_idle = '{
		x: '0,
		y: '0,
		hsync: 1'b1,
		vsync: 1'b1,
		active: 1'b0
	};

endpackage
